// File: verilog/sram_cfg.svh
`ifndef SRAM_CFG_SVH
`define SRAM_CFG_SVH

// word address width, 256k x 16 part
`define SRAM_AW 18

// data pad width
`define SRAM_DW 16

// byte lanes on the data pads, one bw_n strobe each
`define SRAM_NSEL 2

`endif

// File: verilog/wb_bus_pkg.sv
`include "sram_cfg.svh"

package wb_bus_pkg;

  // owner of the access being registered this cycle
  typedef enum logic [1:0] {
    GRANT_NONE = 2'd0,
    GRANT_P0   = 2'd1,
    GRANT_P1   = 2'd2
  } wb_grant_e;

  // one port's request as seen on its wishbone pins
  // adr is a word address, no byte bit
  typedef struct packed {
    logic [`SRAM_AW-1:0]   adr;
    logic [`SRAM_DW-1:0]   dat;
    logic [`SRAM_NSEL-1:0] sel;
    logic                  we;
  } wb_req_t;

endpackage

// File: verilog/sram_pad_pkg.sv
`include "sram_cfg.svh"

package sram_pad_pkg;

  // one pad cycle, already in the sram's own polarity
  // all enables and strobes are active low
  typedef struct packed {
    logic [`SRAM_AW-1:0]   addr;
    logic [`SRAM_DW-1:0]   wdata;
    logic [`SRAM_NSEL-1:0] bw_n;
    logic                  we_n;
    logic                  oe_n;
  } sram_cmd_t;

endpackage

// File: verilog/sram_arbiter.sv
`timescale 1ns/1ps

module sram_arbiter (
  input  logic                  wb_clk_i,
  input  logic                  rst_n_i,
  input  logic                  wb0_stb_i,
  input  logic                  wb0_cyc_i,
  input  logic                  wb1_stb_i,
  input  logic                  wb1_cyc_i,
  output wb_bus_pkg::wb_grant_e grant_o,
  output logic                  load_o,
  output logic                  wb0_ack_o,
  output logic                  wb1_ack_o
);
  import wb_bus_pkg::*;

  logic req0;
  logic req1;

  // live request per port
  // masked in its ack cycle, the master still holds stb there
  assign req0 = wb0_stb_i & wb0_cyc_i & ~wb0_ack_o;
  assign req1 = wb1_stb_i & wb1_cyc_i & ~wb1_ack_o;

  // fixed priority, port 0 first
  // port 1 gets in while port 0 is idle or being acked
  always_comb begin
    if (req0) begin
      grant_o = GRANT_P0;
    end else if (req1) begin
      grant_o = GRANT_P1;
    end else begin
      grant_o = GRANT_NONE;
    end
  end

  // pad registers take the muxed command on any grant
  assign load_o = (grant_o != GRANT_NONE);

  // ack in the cycle after the pad load
  // the sram has then been addressed for a full cycle
  always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb0_ack_o <= 1'b0;
      wb1_ack_o <= 1'b0;
    end else begin
      // one cycle only, the mask above drops the grant next edge
      wb0_ack_o <= (grant_o == GRANT_P0);
      wb1_ack_o <= (grant_o == GRANT_P1);
    end
  end

endmodule

// File: verilog/wb_port_mux.sv
`timescale 1ns/1ps

module wb_port_mux (
  input  wb_bus_pkg::wb_grant_e   grant_i,
  input  wb_bus_pkg::wb_req_t     req0_i,
  input  wb_bus_pkg::wb_req_t     req1_i,
  output sram_pad_pkg::sram_cmd_t cmd_o
);
  import wb_bus_pkg::*;

  wb_req_t sel_req;

  // granted port's request
  // port 0 feeds the path when nobody owns it
  assign sel_req = (grant_i == GRANT_P1) ? req1_i : req0_i;

  always_comb begin
    cmd_o.addr  = sel_req.adr;
    cmd_o.wdata = sel_req.dat;
    // byte selects become write strobes
    // harmless on reads since we_n stays high
    cmd_o.bw_n  = ~sel_req.sel;
    case (grant_i)
      GRANT_P0, GRANT_P1: begin
        // write pulls we_n, read pulls oe_n, never both
        cmd_o.we_n = ~sel_req.we;
        cmd_o.oe_n = sel_req.we;
      end
      default: begin
        // no owner, pads stay quiet
        cmd_o.we_n = 1'b1;
        cmd_o.oe_n = 1'b1;
      end
    endcase
  end

endmodule

// File: verilog/sram_pad_drv.sv
`timescale 1ns/1ps
`include "sram_cfg.svh"

module sram_pad_drv (
  input  logic                    wb_clk_i,
  input  logic                    rst_n_i,
  input  logic                    load_i,
  input  sram_pad_pkg::sram_cmd_t cmd_i,
  output logic [`SRAM_AW-1:0]     sram_addr_o,
  inout  wire  [`SRAM_DW-1:0]     sram_data_io,
  output logic                    sram_we_n_o,
  output logic                    sram_oe_n_o,
  output logic [`SRAM_NSEL-1:0]   sram_bw_n_o,
  output logic [`SRAM_DW-1:0]     rd_data_o
);

  logic [`SRAM_DW-1:0] wdata_q;

  // enables go back to idle on every cycle without a load
  // so each access is exactly one pad cycle
  always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sram_we_n_o <= 1'b1;
      sram_oe_n_o <= 1'b1;
    end else if (load_i) begin
      sram_we_n_o <= cmd_i.we_n;
      sram_oe_n_o <= cmd_i.oe_n;
    end else begin
      sram_we_n_o <= 1'b1;
      sram_oe_n_o <= 1'b1;
    end
  end

  // address, data and strobes only change with a new access
  // they hold through the idle cycles after it
  always_ff @(posedge wb_clk_i) begin
    if (load_i) begin
      sram_addr_o <= cmd_i.addr;
      wdata_q     <= cmd_i.wdata;
      sram_bw_n_o <= cmd_i.bw_n;
    end
  end

  // drive the pads only while a write is registered
  assign sram_data_io = sram_we_n_o ? {`SRAM_DW{1'bz}} : wdata_q;

  // pad data straight back to the bus
  // valid for a read in the ack cycle
  assign rd_data_o = sram_data_io;

endmodule

// File: verilog/wb_sram_top.sv
`timescale 1ns/1ps
`include "sram_cfg.svh"

module wb_sram_top (
  input  logic                  wb_clk_i,
  input  logic                  rst_n_i,

  // port 0, high priority
  input  logic [`SRAM_AW-1:0]   wb0_adr_i,
  input  logic [`SRAM_DW-1:0]   wb0_dat_i,
  input  logic [`SRAM_NSEL-1:0] wb0_sel_i,
  input  logic                  wb0_we_i,
  input  logic                  wb0_stb_i,
  input  logic                  wb0_cyc_i,
  output logic [`SRAM_DW-1:0]   wb0_dat_o,
  output logic                  wb0_ack_o,

  // port 1, served only when port 0 is idle or acked
  input  logic [`SRAM_AW-1:0]   wb1_adr_i,
  input  logic [`SRAM_DW-1:0]   wb1_dat_i,
  input  logic [`SRAM_NSEL-1:0] wb1_sel_i,
  input  logic                  wb1_we_i,
  input  logic                  wb1_stb_i,
  input  logic                  wb1_cyc_i,
  output logic [`SRAM_DW-1:0]   wb1_dat_o,
  output logic                  wb1_ack_o,

  // async sram pads
  output logic [`SRAM_AW-1:0]   sram_addr_o,
  inout  wire  [`SRAM_DW-1:0]   sram_data_io,
  output logic                  sram_we_n_o,
  output logic                  sram_oe_n_o,
  output logic                  sram_ce_n_o,
  output logic [`SRAM_NSEL-1:0] sram_bw_n_o
);
  import wb_bus_pkg::*;
  import sram_pad_pkg::*;

  wb_grant_e             grant;
  logic                  load;
  wb_req_t               req0;
  wb_req_t               req1;
  sram_cmd_t             cmd;
  logic [`SRAM_DW-1:0]   rd_data;

  // loose bus pins gathered per port
  assign req0 = '{adr: wb0_adr_i, dat: wb0_dat_i, sel: wb0_sel_i, we: wb0_we_i};
  assign req1 = '{adr: wb1_adr_i, dat: wb1_dat_i, sel: wb1_sel_i, we: wb1_we_i};

  // both ports read straight off the pads
  // only the acked port samples it
  assign wb0_dat_o = rd_data;
  assign wb1_dat_o = rd_data;

  // single chip, always selected
  assign sram_ce_n_o = 1'b0;

  sram_arbiter u_arbiter (
    .wb_clk_i  (wb_clk_i),
    .rst_n_i   (rst_n_i),
    .wb0_stb_i (wb0_stb_i),
    .wb0_cyc_i (wb0_cyc_i),
    .wb1_stb_i (wb1_stb_i),
    .wb1_cyc_i (wb1_cyc_i),
    .grant_o   (grant),
    .load_o    (load),
    .wb0_ack_o (wb0_ack_o),
    .wb1_ack_o (wb1_ack_o)
  );

  wb_port_mux u_port_mux (
    .grant_i (grant),
    .req0_i  (req0),
    .req1_i  (req1),
    .cmd_o   (cmd)
  );

  sram_pad_drv u_pad_drv (
    .wb_clk_i     (wb_clk_i),
    .rst_n_i      (rst_n_i),
    .load_i       (load),
    .cmd_i        (cmd),
    .sram_addr_o  (sram_addr_o),
    .sram_data_io (sram_data_io),
    .sram_we_n_o  (sram_we_n_o),
    .sram_oe_n_o  (sram_oe_n_o),
    .sram_bw_n_o  (sram_bw_n_o),
    .rd_data_o    (rd_data)
  );

endmodule

// File: tests/sram_async_model.sv
`timescale 1ns/1ps
`include "sram_cfg.svh"

module sram_async_model (
  input  logic [`SRAM_AW-1:0]   addr_i,
  inout  wire  [`SRAM_DW-1:0]   data_io,
  input  logic                  we_n_i,
  input  logic                  oe_n_i,
  input  logic                  ce_n_i,
  input  logic [`SRAM_NSEL-1:0] bw_n_i
);

  // sparse storage, only the touched words exist
  logic [`SRAM_DW-1:0] mem [int];

  // read path, driven only while output enabled and not writing
  assign data_io = (!ce_n_i && !oe_n_i && we_n_i && mem.exists(int'(addr_i))) ?
                   mem[int'(addr_i)] : {`SRAM_DW{1'bz}};

  // level-sensitive write
  // short settle delay so address, data and strobes are all final
  always @(we_n_i or ce_n_i or addr_i or data_io or bw_n_i) begin
    logic [`SRAM_DW-1:0] word;
    #1;
    if (!ce_n_i && !we_n_i) begin
      word = mem.exists(int'(addr_i)) ? mem[int'(addr_i)] : {`SRAM_DW{1'b0}};
      for (int i = 0; i < `SRAM_NSEL; i++) begin
        // each bw_n strobe gates one byte
        if (!bw_n_i[i]) begin
          word[8*i +: 8] = data_io[8*i +: 8];
        end
      end
      mem[int'(addr_i)] = word;
    end
  end

endmodule

// File: tests/wb_sram_assertions.sv
`timescale 1ns/1ps

module wb_sram_assertions (
  input logic clk_i,
  input logic rst_n_i,
  input logic ack0_i,
  input logic ack1_i,
  input logic we_n_i,
  input logic oe_n_i
);

  // running count of failed checks
  int fail_cnt = 0;

  // single-cycle ack on each port
  ack0_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack0_i |=> !ack0_i)
  else begin
    $error("port 0 ack held longer than one cycle");
    fail_cnt++;
  end

  ack1_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack1_i |=> !ack1_i)
  else begin
    $error("port 1 ack held longer than one cycle");
    fail_cnt++;
  end

  // only one access in flight at a time
  acks_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(ack0_i && ack1_i))
  else begin
    $error("both ports acked in the same cycle");
    fail_cnt++;
  end

  // pads never write and read at once
  we_excludes_oe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !we_n_i |-> oe_n_i)
  else begin
    $error("we_n and oe_n low together");
    fail_cnt++;
  end

endmodule

bind wb_sram_top wb_sram_assertions u_assertions (
  .clk_i   (wb_clk_i),
  .rst_n_i (rst_n_i),
  .ack0_i  (wb0_ack_o),
  .ack1_i  (wb1_ack_o),
  .we_n_i  (sram_we_n_o),
  .oe_n_i  (sram_oe_n_o)
);

// File: tests/tb_wb_sram.sv
`timescale 1ns/1ps
`include "sram_cfg.svh"

module tb_wb_sram;

  localparam int ACK_TIMEOUT = 20;

  logic                  wb_clk_i = 1'b0;
  logic                  rst_n_i;
  logic [`SRAM_AW-1:0]   wb0_adr, wb1_adr;
  logic [`SRAM_DW-1:0]   wb0_dat_w, wb1_dat_w, wb0_dat_r, wb1_dat_r;
  logic [`SRAM_NSEL-1:0] wb0_sel, wb1_sel;
  logic                  wb0_we, wb1_we, wb0_stb, wb1_stb, wb0_cyc, wb1_cyc;
  logic                  wb0_ack, wb1_ack;
  logic [`SRAM_AW-1:0]   sram_addr;
  wire  [`SRAM_DW-1:0]   sram_data;
  logic                  sram_we_n, sram_oe_n, sram_ce_n;
  logic [`SRAM_NSEL-1:0] sram_bw_n;

  int                    errors = 0;
  logic [31:0]           rand_state = 32'h0b84_833d;
  // expected memory contents, word addressed
  logic [`SRAM_DW-1:0]   ref_mem [int];

  always #5 wb_clk_i = ~wb_clk_i;

  wb_sram_top u_dut (
    .wb_clk_i (wb_clk_i), .rst_n_i (rst_n_i),
    .wb0_adr_i (wb0_adr), .wb0_dat_i (wb0_dat_w), .wb0_sel_i (wb0_sel),
    .wb0_we_i (wb0_we), .wb0_stb_i (wb0_stb), .wb0_cyc_i (wb0_cyc),
    .wb0_dat_o (wb0_dat_r), .wb0_ack_o (wb0_ack),
    .wb1_adr_i (wb1_adr), .wb1_dat_i (wb1_dat_w), .wb1_sel_i (wb1_sel),
    .wb1_we_i (wb1_we), .wb1_stb_i (wb1_stb), .wb1_cyc_i (wb1_cyc),
    .wb1_dat_o (wb1_dat_r), .wb1_ack_o (wb1_ack),
    .sram_addr_o (sram_addr), .sram_data_io (sram_data), .sram_we_n_o (sram_we_n),
    .sram_oe_n_o (sram_oe_n), .sram_ce_n_o (sram_ce_n), .sram_bw_n_o (sram_bw_n)
  );

  sram_async_model u_sram (
    .addr_i (sram_addr), .data_io (sram_data), .we_n_i (sram_we_n),
    .oe_n_i (sram_oe_n), .ce_n_i (sram_ce_n), .bw_n_i (sram_bw_n)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // only the selected bytes take the new data
  function automatic logic [`SRAM_DW-1:0] merge_lanes(input logic [`SRAM_DW-1:0] old_w,
      input logic [`SRAM_DW-1:0] new_w, input logic [`SRAM_NSEL-1:0] sel);
    logic [`SRAM_DW-1:0] res;
    res = old_w;
    for (int i = 0; i < `SRAM_NSEL; i++) begin
      if (sel[i]) res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

  task automatic check_value(input string name, input logic [`SRAM_DW-1:0] exp,
      input logic [`SRAM_DW-1:0] act);
    assert (act === exp) else begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic end_run();
    int total;
    total = errors + u_dut.u_assertions.fail_cnt;
    $display("check errors: %0d, assertion errors: %0d", errors,
             u_dut.u_assertions.fail_cnt);
    if (total == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  task automatic ack_timeout(input string name);
    $display("%s: no ack within %0d cycles", name, ACK_TIMEOUT);
    errors++;
    end_run();
  endtask

  // one access on one port, waits for ack, returns the read data
  task automatic bus_access(input int port, input logic [`SRAM_AW-1:0] adr,
      input logic [`SRAM_DW-1:0] dat, input logic [`SRAM_NSEL-1:0] sel,
      input logic we, input string name, output logic [`SRAM_DW-1:0] rdata);
    int  cnt;
    logic got;
    cnt = 0;
    got = 1'b0;
    @(posedge wb_clk_i);
    if (port == 0) begin
      wb0_adr   <= adr;
      wb0_dat_w <= dat;
      wb0_sel   <= sel;
      wb0_we    <= we;
      wb0_stb   <= 1'b1;
      wb0_cyc   <= 1'b1;
    end else begin
      wb1_adr   <= adr;
      wb1_dat_w <= dat;
      wb1_sel   <= sel;
      wb1_we    <= we;
      wb1_stb   <= 1'b1;
      wb1_cyc   <= 1'b1;
    end
    while (!got) begin
      @(negedge wb_clk_i);
      got = (port == 0) ? wb0_ack : wb1_ack;
      cnt++;
      if (!got && cnt > ACK_TIMEOUT) ack_timeout(name);
    end
    rdata = (port == 0) ? wb0_dat_r : wb1_dat_r;
    @(posedge wb_clk_i);
    if (port == 0) begin
      wb0_stb <= 1'b0;
      wb0_cyc <= 1'b0;
    end else begin
      wb1_stb <= 1'b0;
      wb1_cyc <= 1'b0;
    end
    if (we) begin
      ref_mem[int'(adr)] = merge_lanes(ref_mem.exists(int'(adr)) ? ref_mem[int'(adr)] : '0,
                                       dat, sel);
    end else begin
      check_value(name, ref_mem.exists(int'(adr)) ? ref_mem[int'(adr)] : 'x, rdata);
    end
  endtask

  task automatic reset_check();
    @(negedge wb_clk_i);
    check_value("reset ack0", 16'h0, {15'h0, wb0_ack});
    check_value("reset ack1", 16'h0, {15'h0, wb1_ack});
    check_value("reset we_n", 16'h1, {15'h0, sram_we_n});
    check_value("reset oe_n", 16'h1, {15'h0, sram_oe_n});
    check_value("reset ce_n", 16'h0, {15'h0, sram_ce_n});
    check_value("reset data bus", 16'hzzzz, sram_data);
  endtask

  task automatic lane_test(input int port, input string name);
    logic [`SRAM_DW-1:0] rd;
    logic [`SRAM_AW-1:0] base;
    base = (port == 0) ? 18'h00010 : 18'h00020;
    bus_access(port, base,         16'h1234, 2'b11, 1'b1, name, rd);
    bus_access(port, base + 18'd1, 16'hbeef, 2'b11, 1'b1, name, rd);
    bus_access(port, base,         16'h00a5, 2'b01, 1'b1, name, rd);
    bus_access(port, base + 18'd1, 16'h7700, 2'b10, 1'b1, name, rd);
    bus_access(port, base,         16'h0,    2'b11, 1'b0, name, rd);
    bus_access(port, base + 18'd1, 16'h0,    2'b11, 1'b0, name, rd);
  endtask

  task automatic priority_test();
    logic [`SRAM_DW-1:0] rd;
    int cyc, cyc0, cyc1;
    bus_access(0, 18'h00040, 16'h1111, 2'b11, 1'b1, "priority preload", rd);
    cyc = 0;
    cyc0 = -1;
    cyc1 = -1;
    @(posedge wb_clk_i);
    wb0_adr   <= 18'h00040;
    wb0_dat_w <= 16'haaaa;
    wb0_sel   <= 2'b11;
    wb0_we    <= 1'b1;
    wb1_adr   <= 18'h00040;
    wb1_dat_w <= 16'h55cc;
    wb1_sel   <= 2'b01;
    wb1_we    <= 1'b1;
    wb0_stb   <= 1'b1;
    wb0_cyc   <= 1'b1;
    wb1_stb   <= 1'b1;
    wb1_cyc   <= 1'b1;
    while (cyc0 < 0 || cyc1 < 0) begin
      @(negedge wb_clk_i);
      cyc++;
      if (wb0_ack && cyc0 < 0) cyc0 = cyc;
      if (wb1_ack && cyc1 < 0) cyc1 = cyc;
      if ((cyc0 < 0 || cyc1 < 0) && cyc > ACK_TIMEOUT) ack_timeout("priority");
      @(posedge wb_clk_i);
      if (cyc0 == cyc) begin
        wb0_stb <= 1'b0;
        wb0_cyc <= 1'b0;
      end
      if (cyc1 == cyc) begin
        wb1_stb <= 1'b0;
        wb1_cyc <= 1'b0;
      end
    end
    assert (cyc0 < cyc1) else begin
      $display("priority: port 0 was not acked before port 1");
      errors++;
    end
    ref_mem[32'h40] = merge_lanes(merge_lanes(ref_mem[32'h40], 16'haaaa, 2'b11),
                                  16'h55cc, 2'b01);
    bus_access(0, 18'h00040, 16'h0, 2'b11, 1'b0, "priority readback", rd);
  endtask

  task automatic random_test();
    logic [`SRAM_DW-1:0] rd;
    int port;
    // known contents first, so every read has a reference
    for (int i = 0; i < 8; i++) begin
      bus_access(i % 2, 18'h00100 + 18'(i), 16'h0f00 + 16'(i), 2'b11, 1'b1,
                 "random fill", rd);
    end
    for (int n = 0; n < 40; n++) begin
      rand_state = lcg_next(rand_state);
      port = rand_state[31] ? 1 : 0;
      bus_access(port, 18'h00100 + rand_state[18:16], rand_state[15:0],
                 (rand_state[21:20] == 2'b00) ? 2'b11 : rand_state[21:20],
                 rand_state[24], "random", rd);
    end
  endtask

  initial begin
    rst_n_i = 1'b0;
    wb0_adr = '0;
    wb0_dat_w = '0;
    wb0_sel = '0;
    wb0_we = 1'b0;
    wb0_stb = 1'b0;
    wb0_cyc = 1'b0;
    wb1_adr = '0;
    wb1_dat_w = '0;
    wb1_sel = '0;
    wb1_we = 1'b0;
    wb1_stb = 1'b0;
    wb1_cyc = 1'b0;
    repeat (2) @(posedge wb_clk_i);
    rst_n_i <= 1'b1;
    reset_check();
    lane_test(0, "port0 lanes");
    lane_test(1, "port1 alone");
    priority_test();
    random_test();
    end_run();
  end

endmodule

// File: all.f
+incdir+verilog
verilog/wb_bus_pkg.sv
verilog/sram_pad_pkg.sv
verilog/sram_arbiter.sv
verilog/wb_port_mux.sv
verilog/sram_pad_drv.sv
verilog/wb_sram_top.sv
tests/sram_async_model.sv
tests/wb_sram_assertions.sv
tests/tb_wb_sram.sv

// File: Makefile
TOOL       ?= verilator
TOP        := tb_wb_sram
FLIST      := all.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(FLIST)
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
